// File: logic/ifu_config.svh
`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

// address and data width.
`define IFU_ADDR_W 32

// cache geometry, both powers of two.
`define IFU_L1I_SETS 4
`define IFU_L1I_LINE_WORDS 2

`define IFU_L1I_IDX_W ($clog2(`IFU_L1I_SETS))
`define IFU_L1I_OFF_W ($clog2(`IFU_L1I_LINE_WORDS))

// first fetch after reset.
`define IFU_PC_INIT 32'h8000_0000

// fence.i, misc-mem opcode with funct3 = 1.
`define IFU_INST_FENCE_I 32'h0000_100f

`endif

// File: logic/ifu_pkg.sv
`include "ifu_config.svh"

package ifu_pkg;

  // major opcodes that matter for fetch stalls.
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    REFILL_IDLE = 2'd0,
    REFILL_REQ  = 2'd1, // read outstanding.
    REFILL_GAP  = 2'd2, // turnaround between beats.
    REFILL_FILL = 2'd3  // line just completed.
  } refill_state_e;

  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   required;
  } bus_req_t;

  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] rdata;
    logic                   rvalid;
  } bus_rsp_t;

  // back-end resolution of an older instruction.
  typedef struct packed {
    logic                   valid;
    logic                   change;
    logic                   retire;
    logic [`IFU_ADDR_W-1:0] npc;
  } redirect_t;

  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] pc;
    logic [`IFU_ADDR_W-1:0] inst;
  } fetch_out_t;

  typedef struct packed {
    logic active;
    logic bad;
    logic good;
  } spec_status_t;

endpackage

// File: logic/refill_beat_counter.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module refill_beat_counter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start_i,
  input  logic                         adv_i,
  output logic [`IFU_L1I_OFF_W-1:0]    beat_offset_o,
  output logic                         last_beat_o
);

  localparam int unsigned LAST = `IFU_L1I_LINE_WORDS - 1;

  logic [`IFU_L1I_OFF_W-1:0] count_q;

  assign last_beat_o   = (count_q == LAST[`IFU_L1I_OFF_W-1:0]);
  assign beat_offset_o = count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (start_i) begin
      count_q <= '0;
    end else if (adv_i) begin
      // wrap after the final word.
      if (last_beat_o) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

// File: logic/l1i_refill_fsm.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module l1i_refill_fsm (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`IFU_ADDR_W-1:0]       fetch_pc_i,
  input  logic                         hit_i,
  input  ifu_pkg::bus_rsp_t            bus_rsp_i,
  input  logic [`IFU_L1I_OFF_W-1:0]    beat_offset_i,
  input  logic                         last_beat_i,
  output ifu_pkg::bus_req_t            bus_req_o,
  output logic                         beat_start_o,
  output logic                         beat_adv_o,
  output logic                         word_we_o,
  output logic                         line_done_o,
  output logic                         busy_o
);

  ifu_pkg::refill_state_e state_q;
  ifu_pkg::refill_state_e state_d;
  logic                   beat_done;

  // a beat lands only while the read is outstanding.
  assign beat_done = (state_q == ifu_pkg::REFILL_REQ) && bus_rsp_i.rvalid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ifu_pkg::REFILL_IDLE: begin
        if (!hit_i) begin
          state_d = ifu_pkg::REFILL_REQ;
        end
      end
      ifu_pkg::REFILL_REQ: begin
        if (bus_rsp_i.rvalid) begin
          state_d = last_beat_i ? ifu_pkg::REFILL_FILL : ifu_pkg::REFILL_GAP;
        end
      end
      ifu_pkg::REFILL_GAP: begin
        state_d = ifu_pkg::REFILL_REQ;
      end
      ifu_pkg::REFILL_FILL: begin
        state_d = ifu_pkg::REFILL_IDLE;
      end
      default: begin
        state_d = ifu_pkg::REFILL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ifu_pkg::REFILL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // pc is frozen while busy, so the line base is stable.
  assign bus_req_o.araddr   = {fetch_pc_i[`IFU_ADDR_W-1:`IFU_L1I_OFF_W+2], beat_offset_i, 2'b00};
  assign bus_req_o.arvalid  = (state_q == ifu_pkg::REFILL_REQ);
  assign bus_req_o.required = (state_q != ifu_pkg::REFILL_IDLE);

  assign beat_start_o = (state_q == ifu_pkg::REFILL_IDLE) && !hit_i;
  assign beat_adv_o   = beat_done;
  assign word_we_o    = beat_done;
  assign line_done_o  = (state_q == ifu_pkg::REFILL_FILL);
  assign busy_o       = (state_q != ifu_pkg::REFILL_IDLE);

endmodule

// File: logic/l1i_array.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module l1i_array (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`IFU_ADDR_W-1:0]       fetch_pc_i,
  input  logic                         word_we_i,
  input  logic [`IFU_L1I_OFF_W-1:0]    word_offset_i,
  input  logic [`IFU_ADDR_W-1:0]       wdata_i,
  input  logic                         line_done_i,
  input  logic                         flush_i,
  output logic                         hit_o,
  output logic [`IFU_ADDR_W-1:0]       rdata_o
);

  localparam int TAG_LSB = `IFU_L1I_IDX_W + `IFU_L1I_OFF_W + 2;
  localparam int TAG_W   = `IFU_ADDR_W - TAG_LSB;

  logic [`IFU_ADDR_W-1:0] data_q [`IFU_L1I_SETS][`IFU_L1I_LINE_WORDS];
  logic [TAG_W-1:0]       tag_q  [`IFU_L1I_SETS];
  logic [`IFU_L1I_SETS-1:0] valid_q;

  logic [TAG_W-1:0]          pc_tag;
  logic [`IFU_L1I_IDX_W-1:0] pc_idx;
  logic [`IFU_L1I_OFF_W-1:0] pc_off;

  assign pc_tag = fetch_pc_i[`IFU_ADDR_W-1:TAG_LSB];
  assign pc_idx = fetch_pc_i[TAG_LSB-1:`IFU_L1I_OFF_W+2];
  assign pc_off = fetch_pc_i[`IFU_L1I_OFF_W+1:2];

  assign hit_o   = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign rdata_o = data_q[pc_idx][pc_off];

  // refill words land at the beat offset, not the pc offset.
  always_ff @(posedge clk) begin
    if (word_we_i) begin
      data_q[pc_idx][word_offset_i] <= wdata_i;
    end
    if (line_done_i) begin
      tag_q[pc_idx] <= pc_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0; // fence.i drops every line.
    end else if (line_done_i) begin
      valid_q[pc_idx] <= 1'b1;
    end
  end

endmodule

// File: logic/fetch_pc_unit.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module fetch_pc_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         hit_i,
  input  logic [`IFU_ADDR_W-1:0]       inst_i,
  input  logic                         busy_i,
  input  logic                         next_ready_i,
  input  ifu_pkg::redirect_t           redirect_i,
  output ifu_pkg::fetch_out_t          fetch_o,
  output logic                         valid_o,
  output logic                         flush_o,
  output ifu_pkg::spec_status_t        spec_o
);

  logic [`IFU_ADDR_W-1:0] pc_q;
  logic [`IFU_ADDR_W-1:0] btb_target_q;
  logic                   btb_valid_q;
  logic [`IFU_ADDR_W-1:0] spec_target_q;
  logic                   spec_q;
  logic                   bad_q;
  logic [`IFU_ADDR_W-1:0] bad_npc_q;
  logic                   good_q;
  logic                   hazard_q;

  ifu_pkg::opcode_e opcode;
  logic             is_ctrl;
  logic             is_load;
  logic             accept;
  logic             resolve;
  logic             bad_now;
  logic             good_now;
  logic             predict;

  assign opcode  = ifu_pkg::opcode_e'(inst_i[6:0]);
  assign is_load = (opcode == ifu_pkg::OP_LOAD);
  assign is_ctrl = (opcode == ifu_pkg::OP_JAL) || (opcode == ifu_pkg::OP_JALR) ||
                   (opcode == ifu_pkg::OP_BRANCH) || (opcode == ifu_pkg::OP_SYSTEM);

  assign resolve  = redirect_i.valid && (redirect_i.change || redirect_i.retire);
  assign bad_now  = resolve && spec_q && (redirect_i.npc != spec_target_q);
  assign good_now = resolve && spec_q && (redirect_i.npc == spec_target_q);

  assign spec_o.active = spec_q;
  assign spec_o.bad    = bad_q || bad_now;
  assign spec_o.good   = good_q;

  // nothing leaves while refilling, stalled or squashing.
  assign valid_o = hit_i && !busy_i && !hazard_q && !spec_o.bad;
  assign accept  = valid_o && next_ready_i;
  assign flush_o = accept && (inst_i == `IFU_INST_FENCE_I);
  assign predict = accept && is_ctrl && btb_valid_q && !spec_q;

  assign fetch_o.pc   = pc_q;
  assign fetch_o.inst = inst_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= `IFU_PC_INIT;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      bad_q       <= 1'b0;
      good_q      <= 1'b0;
      hazard_q    <= 1'b0;
    end else begin
      good_q <= good_now;
      if (resolve && redirect_i.change) begin
        btb_valid_q <= 1'b1;
      end
      if (bad_q && !busy_i) begin
        // squash the wrong path once the refill has drained.
        bad_q    <= 1'b0;
        hazard_q <= 1'b0;
        pc_q     <= bad_npc_q;
      end else if (hazard_q && !spec_q && resolve) begin
        hazard_q <= 1'b0;
        pc_q     <= redirect_i.npc;
      end else if (accept) begin
        if (is_load) begin
          hazard_q <= 1'b1;
        end else if (predict) begin
          pc_q   <= btb_target_q;
          spec_q <= 1'b1;
        end else if (is_ctrl) begin
          hazard_q <= 1'b1; // no target or already speculating.
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
      // first redirect while speculating settles it.
      if (resolve && spec_q) begin
        spec_q <= 1'b0;
        bad_q  <= bad_now;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resolve && redirect_i.change) begin
      btb_target_q <= redirect_i.npc;
    end
    if (predict) begin
      spec_target_q <= btb_target_q;
    end
    if (bad_now) begin
      bad_npc_q <= redirect_i.npc;
    end
  end

endmodule

// File: logic/ifu_top.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module ifu_top (
  input  logic                  clk,
  input  logic                  rst,
  output ifu_pkg::bus_req_t     bus_req_o,
  input  ifu_pkg::bus_rsp_t     bus_rsp_i,
  output ifu_pkg::fetch_out_t   fetch_o,
  output logic                  valid_o,
  input  logic                  next_ready_i,
  input  ifu_pkg::redirect_t    redirect_i,
  output ifu_pkg::spec_status_t spec_o
);

  logic                      hit;
  logic [`IFU_ADDR_W-1:0]    rdata;
  logic                      word_we;
  logic                      line_done;
  logic                      beat_start;
  logic                      beat_adv;
  logic [`IFU_L1I_OFF_W-1:0] beat_offset;
  logic                      last_beat;
  logic                      busy;
  logic                      flush;

  l1i_refill_fsm u_refill_fsm (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_o.pc),
    .hit_i        (hit),
    .bus_rsp_i    (bus_rsp_i),
    .beat_offset_i(beat_offset),
    .last_beat_i  (last_beat),
    .bus_req_o    (bus_req_o),
    .beat_start_o (beat_start),
    .beat_adv_o   (beat_adv),
    .word_we_o    (word_we),
    .line_done_o  (line_done),
    .busy_o       (busy)
  );

  refill_beat_counter u_beat_counter (
    .clk          (clk),
    .rst          (rst),
    .start_i      (beat_start),
    .adv_i        (beat_adv),
    .beat_offset_o(beat_offset),
    .last_beat_o  (last_beat)
  );

  l1i_array u_array (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_o.pc),
    .word_we_i    (word_we),
    .word_offset_i(beat_offset),
    .wdata_i      (bus_rsp_i.rdata),
    .line_done_i  (line_done),
    .flush_i      (flush),
    .hit_o        (hit),
    .rdata_o      (rdata)
  );

  fetch_pc_unit u_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .hit_i       (hit),
    .inst_i      (rdata),
    .busy_i      (busy),
    .next_ready_i(next_ready_i),
    .redirect_i  (redirect_i),
    .fetch_o     (fetch_o),
    .valid_o     (valid_o),
    .flush_o     (flush),
    .spec_o      (spec_o)
  );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o; // 8 ns period.
  end

  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// File: tests/ifu_tb.sv
`timescale 1ns/1ps
`include "ifu_config.svh"

module ifu_tb;

  localparam int NUM_INSTS = 200;
  localparam int MEM_WORDS = 64;
  localparam logic [31:0] BASE       = `IFU_PC_INIT;
  localparam logic [31:0] MEM_END    = `IFU_PC_INIT + 32'd256;
  localparam logic [31:0] LINE_BYTES = `IFU_L1I_LINE_WORDS * 4;
  localparam int P_NONE = 0;
  localparam int P_LOAD = 1;
  localparam int P_HAZ  = 2;
  localparam int P_SPEC = 3;
  localparam int T_RESET  = 0;
  localparam int T_FETCH  = 1;
  localparam int T_CACHE  = 2;
  localparam int T_HAZARD = 3;
  localparam int T_SPEC   = 4;
  localparam int T_HOLD   = 5;

  logic                  clk;
  logic                  rst;
  ifu_pkg::bus_req_t     bus_req;
  ifu_pkg::bus_rsp_t     bus_rsp;
  ifu_pkg::fetch_out_t   fetch;
  logic                  valid;
  logic                  next_ready;
  ifu_pkg::redirect_t    redirect;
  ifu_pkg::spec_status_t spec;

  logic [31:0] word_mem [MEM_WORDS];
  logic [31:0] targets [4];
  logic [31:0] cache_line [`IFU_L1I_SETS];
  logic [`IFU_L1I_SETS-1:0] cache_valid;
  int          checks [6];
  int          errors [6];
  string       test_names [6];

  logic [31:0] stim_seed = 32'd11;
  logic [31:0] rsp_seed  = 32'd11;
  logic [31:0] mem_seed  = 32'd11;
  logic [31:0] exp_pc    = `IFU_PC_INIT;
  logic [31:0] redir_npc;
  logic [31:0] btb_model;
  logic        btb_trained   = 1'b0;
  int          pending       = P_NONE;
  int          delay;
  logic        redir_now     = 1'b0;
  logic        good_due      = 1'b0;
  logic        first_refill  = 1'b0;
  logic        prev_required = 1'b0;
  logic        fence_pending = 1'b0;
  logic        hold_armed    = 1'b0;
  ifu_pkg::fetch_out_t held;
  int          rsp_wait      = -1;
  int          accepted      = 0;
  int          refills       = 0;
  int          fences        = 0;
  int          good_seen     = 0;
  int          bad_seen      = 0;

  tb_clock_gen u_clock (
    .clk_o(clk),
    .rst_o(rst)
  );

  ifu_top DUT (
    .clk         (clk),
    .rst         (rst),
    .bus_req_o   (bus_req),
    .bus_rsp_i   (bus_rsp),
    .fetch_o     (fetch),
    .valid_o     (valid),
    .next_ready_i(next_ready),
    .redirect_i  (redirect),
    .spec_o      (spec)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // words past the program are addi with an address dependent immediate.
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (addr >= BASE && addr < MEM_END) begin
      return word_mem[(addr - BASE) >> 2];
    end
    return {addr[11:0] ^ addr[23:12] ^ {4'd0, addr[31:24]}, 5'd0, 3'b000, 5'd0,
            7'b0010011};
  endfunction

  function automatic logic is_load_op(input logic [31:0] w);
    return w[6:0] == 7'b0000011;
  endfunction

  function automatic logic is_ctrl_op(input logic [31:0] w);
    return (w[6:0] == 7'b1101111) || (w[6:0] == 7'b1100111) ||
           (w[6:0] == 7'b1100011) || (w[6:0] == 7'b1110011);
  endfunction

  function automatic int set_of(input logic [31:0] line);
    return int'((line / LINE_BYTES) % `IFU_L1I_SETS);
  endfunction

  task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp,
                          input int t);
    $display("MISMATCH %s got 0x%08h expected 0x%08h at %0t", sig, got, exp, $time);
    errors[t]++;
  endtask

  task automatic fail_note(input string what, input int t);
    $display("ERROR %s at %0t", what, $time);
    errors[t]++;
  endtask

  task automatic fill_memory();
    int roll;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_seed = lcg_next(mem_seed);
      roll = int'(mem_seed[30:16] % 100);
      if (roll < 70) begin
        word_mem[i] = {mem_seed[11:0], 5'd1, 3'b000, 5'd2, 7'b0010011};
      end else if (roll < 80) begin
        word_mem[i] = {mem_seed[11:0], 5'd3, 3'b010, 5'd4, 7'b0000011};
      end else if (roll < 90) begin
        word_mem[i] = {mem_seed[31:12], 5'd1, 7'b1101111};
      end else begin
        word_mem[i] = {7'd0, 5'd5, 5'd6, 3'b000, 5'd8, 7'b1100011};
      end
    end
    word_mem[13] = `IFU_INST_FENCE_I; // just after a jump target.
    targets[0] = BASE;
    targets[1] = BASE + 32'h30;
    targets[2] = BASE + 32'h64;
    targets[3] = BASE + 32'ha8;
  endtask

  task automatic drive_backend();
    redirect  = '0;
    redir_now = 1'b0;
    if (pending != P_NONE) begin
      next_ready = 1'b0; // back end stalls until it resolves.
      if (delay == 0) begin
        redirect.valid  = 1'b1;
        redirect.change = (pending != P_LOAD);
        redirect.retire = (pending == P_LOAD);
        redirect.npc    = redir_npc;
        redir_now       = 1'b1;
      end else begin
        delay--;
      end
    end else begin
      stim_seed  = lcg_next(stim_seed);
      next_ready = (stim_seed[30:16] % 4) != 0;
    end
  endtask

  task automatic refill_started();
    logic [31:0] line;
    int          idx;
    line = bus_req.araddr & ~(LINE_BYTES - 32'd1);
    idx  = set_of(line);
    if (!first_refill) begin
      checks[T_RESET]++;
      if (bus_req.araddr != (BASE & ~(LINE_BYTES - 32'd1))) begin
        mismatch("bus_req_o.araddr", bus_req.araddr, BASE & ~(LINE_BYTES - 32'd1), T_RESET);
      end
      first_refill = 1'b1;
    end
    checks[T_CACHE]++;
    if (cache_valid[idx] && cache_line[idx] == line) begin
      fail_note("refill requested for a line that is still cached", T_CACHE);
    end
    cache_valid[idx] = 1'b1;
    cache_line[idx]  = line;
    fence_pending    = 1'b0;
    refills++;
  endtask

  task automatic resolve_redirect();
    if (pending == P_SPEC) begin
      checks[T_SPEC] += 2;
      if (!spec.active) begin
        mismatch("spec_o.active", 32'(spec.active), 32'd1, T_SPEC);
      end
      if (spec.bad != (redir_npc != btb_model)) begin
        mismatch("spec_o.bad", 32'(spec.bad), 32'(redir_npc != btb_model), T_SPEC);
      end
      if (redir_npc == btb_model) begin
        good_due = 1'b1;
        good_seen++;
      end else begin
        bad_seen++;
      end
    end
    if (pending != P_LOAD) begin
      btb_model   = redir_npc;
      btb_trained = 1'b1;
    end
    exp_pc  = redir_npc;
    pending = P_NONE;
  endtask

  task automatic accept_fetch();
    logic [31:0] word;
    word = mem_word(exp_pc);
    checks[T_FETCH] += 2;
    if (fetch.pc != exp_pc) begin
      mismatch("fetch_o.pc", fetch.pc, exp_pc, T_FETCH);
    end
    if (fetch.inst != word) begin
      mismatch("fetch_o.inst", fetch.inst, word, T_FETCH);
    end
    checks[T_CACHE]++;
    if (fence_pending) begin
      fail_note("fetch after fence.i served without a refill", T_CACHE);
    end
    accepted++;
    stim_seed = lcg_next(stim_seed);
    delay     = int'(stim_seed[30:16] % 3);
    if (is_load_op(word)) begin
      pending   = P_LOAD;
      redir_npc = exp_pc + 32'd4;
    end else if (is_ctrl_op(word)) begin
      stim_seed = lcg_next(stim_seed);
      if (btb_trained && stim_seed[20]) begin
        redir_npc = btb_model; // same target again.
      end else begin
        redir_npc = targets[stim_seed[17:16]];
      end
      pending = btb_trained ? P_SPEC : P_HAZ;
    end else begin
      exp_pc = exp_pc + 32'd4;
      if (word == `IFU_INST_FENCE_I) begin
        cache_valid   = '0;
        fence_pending = 1'b1;
        fences++;
      end
    end
  endtask

  task automatic sample_cycle();
    if (bus_req.arvalid && !prev_required) begin
      refill_started();
    end
    prev_required = bus_req.required;
    if (!first_refill) begin
      checks[T_RESET]++;
      if (valid || bus_req.required || spec != '0) begin
        fail_note("valid_o, required or spec_o raised before the first refill", T_RESET);
      end
    end
    if (good_due) begin
      checks[T_SPEC]++;
      if (!spec.good) begin
        fail_note("no spec_o.good pulse after a correct prediction", T_SPEC);
      end
      good_due = 1'b0;
    end
    if (hold_armed && valid) begin
      checks[T_HOLD] += 2;
      if (fetch.pc != held.pc) begin
        mismatch("fetch_o.pc", fetch.pc, held.pc, T_HOLD);
      end
      if (fetch.inst != held.inst) begin
        mismatch("fetch_o.inst", fetch.inst, held.inst, T_HOLD);
      end
    end
    hold_armed = valid && !next_ready;
    held       = fetch;
    if (pending == P_LOAD || pending == P_HAZ) begin
      checks[T_HAZARD]++;
      if (valid) begin
        fail_note("valid_o raised while waiting for a redirect", T_HAZARD);
      end
    end
    if (redir_now) begin
      resolve_redirect();
    end else if (valid && next_ready) begin
      accept_fetch();
    end
  endtask

  // memory responder with 1 to 4 cycles of arvalid per beat.
  initial begin
    bus_rsp = '0;
    forever begin
      @(posedge clk);
      #1;
      bus_rsp.rvalid = 1'b0;
      if (bus_req.arvalid) begin
        if (rsp_wait < 0) begin
          rsp_seed = lcg_next(rsp_seed);
          rsp_wait = int'(rsp_seed[30:16] % 4);
        end
        if (rsp_wait == 0) begin
          bus_rsp.rvalid = 1'b1;
          bus_rsp.rdata  = mem_word(bus_req.araddr);
          rsp_wait       = -1;
        end else begin
          rsp_wait--;
        end
      end
    end
  end

  initial begin
    #(NUM_INSTS * 200 * 8);
    $display("timeout with %0d of %0d instructions accepted", accepted, NUM_INSTS);
    $display("Checks failed");
    $finish;
  end

  initial begin
    int total_checks;
    int total_errors;
    next_ready    = 1'b0;
    redirect      = '0;
    cache_valid   = '0;
    test_names[0] = "reset_state";
    test_names[1] = "fetch_order";
    test_names[2] = "cache_refill";
    test_names[3] = "hazard_stall";
    test_names[4] = "speculation";
    test_names[5] = "back_pressure";
    fill_memory();
    while (rst) begin
      @(negedge clk);
      checks[T_RESET]++;
      if (valid || bus_req.arvalid || bus_req.required || spec != '0) begin
        fail_note("outputs active during reset", T_RESET);
      end
    end
    while (accepted < NUM_INSTS) begin
      @(posedge clk);
      #1;
      drive_backend();
      @(negedge clk);
      sample_cycle();
    end
    repeat (4) @(posedge clk);
    total_checks = 0;
    total_errors = 0;
    for (int t = 0; t < 6; t++) begin
      $display("test %s %s checks %0d errors %0d", test_names[t],
               (errors[t] == 0) ? "ok" : "FAIL", checks[t], errors[t]);
      total_checks += checks[t];
      total_errors += errors[t];
    end
    $display("accepted %0d refills %0d fences %0d good %0d bad %0d checks %0d errors %0d",
             accepted, refills, fences, good_seen, bad_seen, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+logic
logic/ifu_pkg.sv
logic/refill_beat_counter.sv
logic/l1i_refill_fsm.sv
logic/l1i_array.sv
logic/fetch_pc_unit.sv
logic/ifu_top.sv
tests/tb_clock_gen.sv
tests/ifu_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing
LINT      := --lint-only --timing
TOP       := ifu_tb
FILELIST  := list.f
BUILD     := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard logic/*.sv logic/*.svh tests/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides the result, not the exit code of the binary.
run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
